/* wb_params.svh */
// widths, SPR indices, exception vectors and MSR masks shared by the writeback stage and its testbench
`ifndef WB_PARAMS_SVH
`define WB_PARAMS_SVH

////////////////////////////////////////
// datapath widths

`define WB_REGSZ       32    // GPR and SPR width
`define WB_XERCRSZ     64    // XER and CR travel together
`define WB_SPR_BITS    6     // SPR file index

////////////////////////////////////////
// SPR indices written by the exception path

`define WB_SPR_SRR0    6'd0
`define WB_SPR_SRR1    6'd1
`define WB_SPR_DAR     6'd2
`define WB_SPR_DSISR   6'd3

////////////////////////////////////////
// exception vectors, offsets from the vector base

`define WB_VEC_DSI       32'h0000_0300
`define WB_VEC_ISI       32'h0000_0400
`define WB_VEC_ALIGN     32'h0000_0600
`define WB_VEC_PROGRAM   32'h0000_0700
`define WB_VEC_SYSCALL   32'h0000_0c00

`define WB_HIGH_VEC_BASE 32'hfff0_0000   // used when MSR[IP] is set

// MSR bits
`define WB_MSR_IP        32'h0000_0040
// EE, PR, IR and DR, cleared on exception entry
`define WB_MSR_CLEAR     32'h0000_c030

// DSISR bits
`define WB_DSISR_PAGE    32'h4000_0000   // no translation found
`define WB_DSISR_STORE   32'h0200_0000   // faulting access was a store

`endif

/* wb_pkg.sv */
// fault codes, write-port sources and the packed bundles passed between writeback blocks and the testbench
`include "wb_params.svh"

package wb_pkg;

   ////////////////////////////////////////
   // enums

   // fault code from the memory stage, none means a normal result
   typedef enum logic [3:0] {
      fault_none      = 4'd0,
      fault_isi       = 4'd1,
      fault_dsi_load  = 4'd2,
      fault_dsi_store = 4'd3,
      fault_align     = 4'd4,
      fault_program   = 4'd5,
      fault_syscall   = 4'd6
   } fault_e;

   // value source of GPR port 0 and the special SPR port
   typedef enum logic [2:0] {
      src_r0      = 3'd0,
      src_r1      = 3'd1,
      src_mem_res = 3'd2,
      src_sxt16   = 3'd3,   // sign-extended halfword load
      src_bswap16 = 3'd4,   // byte-reversed halfword load
      src_bswap32 = 3'd5    // byte-reversed word load
   } wb_src_e;

   ////////////////////////////////////////
   // inputs from the memory stage

   // decode controls, 34 bits
   typedef struct packed {
      logic                    gpr0_en;
      logic [4:0]              gpr0_reg;
      wb_src_e                 gpr0_src;
      logic                    gpr1_en;
      logic [4:0]              gpr1_reg;
      logic                    spr_en;
      logic [`WB_SPR_BITS-1:0] spr_idx;
      logic                    sspr_en;
      logic [`WB_SPR_BITS-1:0] sspr_idx;
      wb_src_e                 sspr_src;   // r0 or r1 only
      logic                    xercr_en;
      logic                    unlock_generic;
   } wb_bundle_t;

   typedef struct packed {
      logic [`WB_REGSZ-1:0]   r0;
      logic [`WB_REGSZ-1:0]   r1;
      logic [`WB_REGSZ-1:0]   res;    // load or ALU result
      logic [`WB_REGSZ-1:0]   addr;   // effective address, DAR on a DSI
      logic [`WB_XERCRSZ-1:0] rc;
   } wb_operands_t;

   typedef struct packed {
      logic                 valid;
      fault_e               fault;
      logic [`WB_REGSZ-1:0] pc;
      logic [31:0]          msr;
   } wb_in_t;

   ////////////////////////////////////////
   // register-file and fetch outputs

   typedef struct packed {
      logic                 en;
      logic [4:0]           regnum;
      logic [`WB_REGSZ-1:0] value;
   } gpr_wr_t;

   typedef struct packed {
      logic                    en;
      logic [`WB_SPR_BITS-1:0] regnum;
      logic [`WB_REGSZ-1:0]    value;
   } spr_wr_t;

   typedef struct packed {
      logic                   en;
      logic [`WB_XERCRSZ-1:0] value;
   } xercr_wr_t;

   typedef struct packed {
      logic                 valid;
      logic [`WB_REGSZ-1:0] pc;
      logic [31:0]          msr;
   } pcmsr_t;

endpackage

/* wb_exc_calc.sv */
// combinational exception calculation, instantiated by the writeback top to feed the exception sequencer
`timescale 1ns/100ps
`include "wb_params.svh"

module wb_exc_calc
   import wb_pkg::*;
(
   input  fault_e               fault,
   input  logic [`WB_REGSZ-1:0] pc,
   input  logic [31:0]          msr,

   output logic [`WB_REGSZ-1:0] saved_pc,    // to SRR0
   output logic [31:0]          saved_msr,   // to SRR1
   output logic [`WB_REGSZ-1:0] new_pc,
   output logic [31:0]          new_msr,
   output logic [31:0]          dsisr,
   output logic                 two_cycle    // DSI needs DAR/DSISR first
);

   logic [`WB_REGSZ-1:0] vector;
   logic [`WB_REGSZ-1:0] vec_base;
   logic                 is_dsi;
   logic                 is_syscall;

   ////////////////////////////////////////
   // vector select

   always_comb begin
      case (fault)
         fault_isi:       vector = `WB_VEC_ISI;
         fault_dsi_load,
         fault_dsi_store: vector = `WB_VEC_DSI;
         fault_align:     vector = `WB_VEC_ALIGN;
         fault_program:   vector = `WB_VEC_PROGRAM;
         fault_syscall:   vector = `WB_VEC_SYSCALL;
         default:         vector = '0;   // no fault, result unused
      endcase
   end

   // IP picks the high vector table
   assign vec_base = ((msr & `WB_MSR_IP) != 32'h0) ? `WB_HIGH_VEC_BASE : '0;

   assign new_pc = vec_base + vector;

   ////////////////////////////////////////
   // saved state

   assign is_syscall = (fault == fault_syscall);

   // sc resumes after itself, everything else re-executes
   assign saved_pc  = is_syscall ? (pc + 32'd4) : pc;
   assign saved_msr = msr;

   // translation off, supervisor, interrupts masked
   assign new_msr = msr & ~`WB_MSR_CLEAR;

   ////////////////////////////////////////
   // data storage faults

   assign is_dsi = (fault == fault_dsi_load) || (fault == fault_dsi_store);

   always_comb begin
      dsisr = `WB_DSISR_PAGE;
      if (fault == fault_dsi_store) begin
         dsisr = dsisr | `WB_DSISR_STORE;
      end
   end

   assign two_cycle = is_dsi;

endmodule

/* wb_exc_sequencer.sv */
// two-state exception sequencer of the writeback stage, drives commit, annul, exception SPR writes and new PC/MSR
`timescale 1ns/100ps
`include "wb_params.svh"

module wb_exc_sequencer
   import wb_pkg::*;
(
   input  logic                 clk,
   input  logic                 reset,

   input  wb_in_t               mem_in,
   input  logic [`WB_REGSZ-1:0] addr,

   // from the exception calculation
   input  logic [`WB_REGSZ-1:0] saved_pc,
   input  logic [31:0]          saved_msr,
   input  logic [`WB_REGSZ-1:0] new_pc,
   input  logic [31:0]          new_msr,
   input  logic [31:0]          dsisr,
   input  logic                 two_cycle,

   output logic                 commit,
   output logic                 annul,
   output spr_wr_t              exc_spr,     // DAR or SRR0
   output spr_wr_t              exc_sspr,    // DSISR or SRR1
   output pcmsr_t               new_pcmsr
);

   typedef enum logic {
      st_normal,
      st_second_cycle
   } seq_state_e;

   seq_state_e state;

   logic fault_cycle;
   logic first_cycle;     // DAR/DSISR cycle of a DSI
   logic one_cycle_exc;
   logic second_cycle;    // SRR0/SRR1 cycle of a DSI
   logic take_exc;        // SRR writes plus redirect

   ////////////////////////////////////////
   // cycle decode

   assign fault_cycle   = mem_in.valid && (mem_in.fault != fault_none);
   assign first_cycle   = fault_cycle && (state == st_normal) && two_cycle;
   assign one_cycle_exc = fault_cycle && !first_cycle;

   // memory stage was annulled last cycle, so valid is low here
   assign second_cycle  = (state == st_second_cycle) && !mem_in.valid;
   assign take_exc      = one_cycle_exc || second_cycle;

   assign commit = mem_in.valid && (mem_in.fault == fault_none);
   assign annul  = fault_cycle;

   ////////////////////////////////////////
   // exception writes and redirect

   always_comb begin
      exc_spr   = '0;
      exc_sspr  = '0;
      new_pcmsr = '0;

      if (first_cycle) begin
         exc_spr.en      = 1'b1;
         exc_spr.regnum  = `WB_SPR_DAR;
         exc_spr.value   = addr;
         exc_sspr.en     = 1'b1;
         exc_sspr.regnum = `WB_SPR_DSISR;
         exc_sspr.value  = dsisr;
      end else if (take_exc) begin
         exc_spr.en      = 1'b1;
         exc_spr.regnum  = `WB_SPR_SRR0;
         exc_spr.value   = saved_pc;
         exc_sspr.en     = 1'b1;
         exc_sspr.regnum = `WB_SPR_SRR1;
         exc_sspr.value  = saved_msr;
         new_pcmsr.valid = 1'b1;
         new_pcmsr.pc    = new_pc;
         new_pcmsr.msr   = new_msr;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= st_normal;
      end else if (first_cycle) begin
         state <= st_second_cycle;
      end else if (state == st_second_cycle) begin
         state <= st_normal;   // second cycle always finishes
      end
   end

   ////////////////////////////////////////
   // checks on the memory stage

   a_second_cycle_idle: assert property (
      @(posedge clk) disable iff (reset)
      (state == st_second_cycle) |-> !mem_in.valid);

   a_fault_code_range: assert property (
      @(posedge clk) disable iff (reset)
      mem_in.valid |-> (mem_in.fault <= fault_syscall));

endmodule

/* wb_port_select.sv */
// builds the register-file write ports of the writeback stage, exception SPR writes override normal ones
`timescale 1ns/100ps
`include "wb_params.svh"

module wb_port_select
   import wb_pkg::*;
(
   input  wb_bundle_t   bundle,
   input  wb_operands_t ops,
   input  logic         commit,      // valid, fault free
   input  spr_wr_t      exc_spr,
   input  spr_wr_t      exc_sspr,

   output gpr_wr_t      gpr0,
   output gpr_wr_t      gpr1,
   output spr_wr_t      spr,
   output spr_wr_t      sspr,
   output xercr_wr_t    xercr,
   output logic         unlock_generic
);

   logic [`WB_REGSZ-1:0] gpr0_value;
   logic [`WB_REGSZ-1:0] sspr_value;

   ////////////////////////////////////////
   // value sources

   // load transforms sit on port 0 only
   always_comb begin
      case (bundle.gpr0_src)
         src_r0:      gpr0_value = ops.r0;
         src_r1:      gpr0_value = ops.r1;
         src_mem_res: gpr0_value = ops.res;
         src_sxt16: begin
            gpr0_value = {{(`WB_REGSZ-16){ops.res[15]}}, ops.res[15:0]};
         end
         src_bswap16: begin
            gpr0_value = {{(`WB_REGSZ-16){1'b0}}, ops.res[7:0], ops.res[15:8]};
         end
         src_bswap32: begin
            gpr0_value = {ops.res[7:0], ops.res[15:8], ops.res[23:16], ops.res[31:24]};
         end
         default:     gpr0_value = '0;
      endcase
   end

   always_comb begin
      case (bundle.sspr_src)
         src_r0:  sspr_value = ops.r0;
         src_r1:  sspr_value = ops.r1;
         default: sspr_value = '0;   // no other path to the special port
      endcase
   end

   ////////////////////////////////////////
   // write ports

   always_comb begin
      gpr0  = '0;
      gpr1  = '0;
      spr   = '0;
      sspr  = '0;
      xercr = '0;

      if (commit && bundle.gpr0_en) begin
         gpr0.en     = 1'b1;
         gpr0.regnum = bundle.gpr0_reg;
         gpr0.value  = gpr0_value;
      end

      if (commit && bundle.gpr1_en) begin
         gpr1.en     = 1'b1;
         gpr1.regnum = bundle.gpr1_reg;
         gpr1.value  = ops.r0;
      end

      // SPR and special SPR may both be written in one cycle
      if (exc_spr.en) begin
         spr = exc_spr;
      end else if (commit && bundle.spr_en) begin
         spr.en     = 1'b1;
         spr.regnum = bundle.spr_idx;
         spr.value  = ops.r0;
      end

      if (exc_sspr.en) begin
         sspr = exc_sspr;
      end else if (commit && bundle.sspr_en) begin
         sspr.en     = 1'b1;
         sspr.regnum = bundle.sspr_idx;
         sspr.value  = sspr_value;
      end

      if (commit && bundle.xercr_en) begin
         xercr.en    = 1'b1;
         xercr.value = ops.rc;
      end
   end

   // generic lock release is separate from per-register tracking in decode
   assign unlock_generic = commit && bundle.unlock_generic;

   // decode never routes a load result to the special port
   a_sspr_src: assert final (!(commit && bundle.sspr_en) ||
                             (bundle.sspr_src inside {src_r0, src_r1}));

endmodule

/* writeback.sv */
// top of the writeback stage, connects exception calculation, sequencer and write-port selection
`timescale 1ns/100ps
`include "wb_params.svh"

module writeback
   import wb_pkg::*;
(
   input  logic         clk,
   input  logic         reset,

   // from the memory stage
   input  wb_in_t       mem_in,
   input  wb_bundle_t   bundle,
   input  wb_operands_t ops,

   // to the register files
   output gpr_wr_t      gpr0,
   output gpr_wr_t      gpr1,
   output spr_wr_t      spr,
   output spr_wr_t      sspr,
   output xercr_wr_t    xercr,
   output logic         unlock_generic,

   // to fetch
   output pcmsr_t       new_pcmsr,
   output logic         annul
);

   logic [`WB_REGSZ-1:0] exc_saved_pc;
   logic [31:0]          exc_saved_msr;
   logic [`WB_REGSZ-1:0] exc_new_pc;
   logic [31:0]          exc_new_msr;
   logic [31:0]          exc_dsisr;
   logic                 two_cycle;

   logic                 commit;
   spr_wr_t              exc_spr;
   spr_wr_t              exc_sspr;

   wb_exc_calc i_exc_calc (
      .fault     (mem_in.fault),
      .pc        (mem_in.pc),
      .msr       (mem_in.msr),
      .saved_pc  (exc_saved_pc),
      .saved_msr (exc_saved_msr),
      .new_pc    (exc_new_pc),
      .new_msr   (exc_new_msr),
      .dsisr     (exc_dsisr),
      .two_cycle (two_cycle)
   );

   wb_exc_sequencer i_exc_sequencer (
      .clk       (clk),
      .reset     (reset),
      .mem_in    (mem_in),
      .addr      (ops.addr),
      .saved_pc  (exc_saved_pc),
      .saved_msr (exc_saved_msr),
      .new_pc    (exc_new_pc),
      .new_msr   (exc_new_msr),
      .dsisr     (exc_dsisr),
      .two_cycle (two_cycle),
      .commit    (commit),
      .annul     (annul),
      .exc_spr   (exc_spr),
      .exc_sspr  (exc_sspr),
      .new_pcmsr (new_pcmsr)
   );

   wb_port_select i_port_select (
      .bundle         (bundle),
      .ops            (ops),
      .commit         (commit),
      .exc_spr        (exc_spr),
      .exc_sspr       (exc_sspr),
      .gpr0           (gpr0),
      .gpr1           (gpr1),
      .spr            (spr),
      .sspr           (sspr),
      .xercr          (xercr),
      .unlock_generic (unlock_generic)
   );

endmodule

/* tb_writeback.sv */
// self-checking testbench that applies a table of stimulus rows to the writeback stage and checks every output
`timescale 1ns/100ps
`include "wb_params.svh"

module tb_writeback
   import wb_pkg::*;
();

   // one table row with the stimulus first and the expected outputs after it
   typedef struct packed {
      wb_in_t       mem_in;
      wb_bundle_t   bundle;
      wb_operands_t ops;
      gpr_wr_t      gpr0;
      gpr_wr_t      gpr1;
      spr_wr_t      spr;
      spr_wr_t      sspr;
      xercr_wr_t    xercr;
      logic         unlock;
      pcmsr_t       pcmsr;
      logic         annul;
   } row_t;

   logic         clk;
   logic         reset;
   wb_in_t       mem_in;
   wb_bundle_t   bundle;
   wb_operands_t ops;
   gpr_wr_t      gpr0;
   gpr_wr_t      gpr1;
   spr_wr_t      spr;
   spr_wr_t      sspr;
   xercr_wr_t    xercr;
   logic         unlock_generic;
   pcmsr_t       new_pcmsr;
   logic         annul;

   row_t        rows[$];
   logic [31:0] rng;
   logic        dsi_pending;   // second DSI cycle expected next
   logic        table_done;
   int          watchdog_ns;

   writeback i_writeback (
      .clk            (clk),
      .reset          (reset),
      .mem_in         (mem_in),
      .bundle         (bundle),
      .ops            (ops),
      .gpr0           (gpr0),
      .gpr1           (gpr1),
      .spr            (spr),
      .sspr           (sspr),
      .xercr          (xercr),
      .unlock_generic (unlock_generic),
      .new_pcmsr      (new_pcmsr),
      .annul          (annul)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;   // 8 ns period
   end

   ////////////////////////////////////////
   // reference rules

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic logic [31:0] next_word();
      rng = xorshift32(rng);
      return rng;
   endfunction

   function automatic logic [31:0] exc_vector(input fault_e f);
      case (f)
         fault_isi:       return `WB_VEC_ISI;
         fault_dsi_load:  return `WB_VEC_DSI;
         fault_dsi_store: return `WB_VEC_DSI;
         fault_align:     return `WB_VEC_ALIGN;
         fault_program:   return `WB_VEC_PROGRAM;
         fault_syscall:   return `WB_VEC_SYSCALL;
         default:         return 32'h0;
      endcase
   endfunction

   // GPR port 0 value with the load transforms
   function automatic logic [31:0] gpr0_source(input wb_src_e src, input wb_operands_t o);
      logic [31:0] v;
      v = 32'h0;
      case (src)
         src_r0:      v = o.r0;
         src_r1:      v = o.r1;
         src_mem_res: v = o.res;
         src_sxt16:   v = $signed(o.res[15:0]);
         src_bswap16: v = {16'h0, o.res[7:0], o.res[15:8]};
         src_bswap32: begin
            for (int k = 0; k < 4; k++) begin
               v[8*k +: 8] = o.res[8*(3-k) +: 8];
            end
         end
         default:     v = 32'h0;
      endcase
      return v;
   endfunction

   // fills a row with random operands and its expected outputs
   task automatic add_row(input logic valid, input fault_e fault, input wb_bundle_t b,
                          input logic [31:0] pc, input logic [31:0] msr);
      row_t        r;
      logic        commit;
      logic [31:0] base;
      logic [31:0] saved_pc;
      logic [31:0] dsisr;
      r = '0;
      r.mem_in = '{valid, fault, pc, msr};
      r.bundle = b;
      r.ops.r0 = next_word();
      r.ops.r1 = next_word();
      r.ops.res = next_word();
      r.ops.addr = next_word();
      r.ops.rc[63:32] = next_word();
      r.ops.rc[31:0] = next_word();
      commit = valid && (fault == fault_none);
      base = ((msr & `WB_MSR_IP) != 32'h0) ? `WB_HIGH_VEC_BASE : 32'h0;
      saved_pc = (fault == fault_syscall) ? pc + 32'd4 : pc;
      dsisr = `WB_DSISR_PAGE;
      if (fault == fault_dsi_store) dsisr = dsisr | `WB_DSISR_STORE;
      if (commit) begin
         if (b.gpr0_en) r.gpr0 = '{1'b1, b.gpr0_reg, gpr0_source(b.gpr0_src, r.ops)};
         if (b.gpr1_en) r.gpr1 = '{1'b1, b.gpr1_reg, r.ops.r0};
         if (b.spr_en) r.spr = '{1'b1, b.spr_idx, r.ops.r0};
         if (b.sspr_en) begin
            r.sspr = '{1'b1, b.sspr_idx, (b.sspr_src == src_r1) ? r.ops.r1 : r.ops.r0};
         end
         if (b.xercr_en) r.xercr = '{1'b1, r.ops.rc};
         r.unlock = b.unlock_generic;
      end else if (valid && (fault inside {fault_dsi_load, fault_dsi_store}) && !dsi_pending) begin
         r.annul = 1'b1;   // DAR/DSISR cycle
         r.spr = '{1'b1, `WB_SPR_DAR, r.ops.addr};
         r.sspr = '{1'b1, `WB_SPR_DSISR, dsisr};
         dsi_pending = 1'b1;
      end else if (valid || dsi_pending) begin
         r.annul = valid;   // low in the second DSI cycle
         r.spr = '{1'b1, `WB_SPR_SRR0, saved_pc};
         r.sspr = '{1'b1, `WB_SPR_SRR1, msr};
         r.pcmsr = '{1'b1, base + exc_vector(fault), msr & ~`WB_MSR_CLEAR};
         dsi_pending = 1'b0;
      end
      rows.push_back(r);
   endtask

   task automatic build_table();
      wb_bundle_t  b;
      wb_bundle_t  all_b;
      fault_e      one_cycle[4];
      fault_e      dsi_fault;
      logic [31:0] pc;
      logic [31:0] msr;
      int          last;
      all_b = '0;
      all_b.gpr0_en = 1'b1;
      all_b.gpr0_reg = 5'd7;
      all_b.gpr0_src = src_bswap32;
      all_b.gpr1_en = 1'b1;
      all_b.gpr1_reg = 5'd12;
      all_b.spr_en = 1'b1;
      all_b.spr_idx = 6'd40;
      all_b.sspr_en = 1'b1;
      all_b.sspr_idx = 6'd41;
      all_b.sspr_src = src_r1;
      all_b.xercr_en = 1'b1;
      all_b.unlock_generic = 1'b1;

      // idle rows ignore requests without valid
      add_row(1'b0, fault_none, '0, next_word(), next_word());
      add_row(1'b0, fault_none, all_b, next_word(), next_word());

      for (int s = 0; s < 6; s++) begin
         b = '0;
         b.gpr0_en = 1'b1;
         b.gpr0_reg = 5'(s + 1);
         b.gpr0_src = wb_src_e'(s);
         for (int k = 0; k < 2; k++) begin
            add_row(1'b1, fault_none, b, next_word(), next_word());
            last = rows.size() - 1;
            rows[last].ops.res[15] = 1'(k);   // one row of each halfword sign
            rows[last].gpr0.value = gpr0_source(b.gpr0_src, rows[last].ops);
         end
      end

      // one port per row
      b = '0;
      b.gpr1_en = 1'b1;
      b.gpr1_reg = 5'd9;
      add_row(1'b1, fault_none, b, next_word(), next_word());
      b = '0;
      b.spr_en = 1'b1;
      b.spr_idx = 6'd17;
      add_row(1'b1, fault_none, b, next_word(), next_word());
      b = '0;
      b.sspr_en = 1'b1;
      b.sspr_idx = 6'd22;
      b.sspr_src = src_r1;
      add_row(1'b1, fault_none, b, next_word(), next_word());
      b.sspr_src = src_r0;
      add_row(1'b1, fault_none, b, next_word(), next_word());
      b = '0;
      b.xercr_en = 1'b1;
      add_row(1'b1, fault_none, b, next_word(), next_word());
      b = '0;
      b.unlock_generic = 1'b1;
      add_row(1'b1, fault_none, b, next_word(), next_word());
      add_row(1'b1, fault_none, all_b, next_word(), next_word());

      ////////////////////////////////////////
      // faults with a bundle that asks for every write
      one_cycle[0] = fault_isi;
      one_cycle[1] = fault_align;
      one_cycle[2] = fault_program;
      one_cycle[3] = fault_syscall;
      for (int f = 0; f < 4; f++) begin
         for (int ip = 0; ip < 2; ip++) begin
            msr = next_word() & ~`WB_MSR_IP;
            if (ip == 1) msr = msr | `WB_MSR_IP;
            add_row(1'b1, one_cycle[f], all_b, next_word(), msr);
         end
      end

      for (int d = 0; d < 2; d++) begin
         dsi_fault = fault_dsi_load;
         if (d == 1) dsi_fault = fault_dsi_store;
         pc = next_word();
         msr = next_word() & ~`WB_MSR_IP;
         if (d == 1) msr = msr | `WB_MSR_IP;
         add_row(1'b1, dsi_fault, all_b, pc, msr);
         add_row(1'b0, dsi_fault, all_b, pc, msr);   // fault, pc and msr held
         add_row(1'b1, fault_none, all_b, next_word(), next_word());
      end
      add_row(1'b0, fault_none, '0, next_word(), next_word());
   endtask

   ////////////////////////////////////////
   // drive and compare

   task automatic apply_row(input row_t r);
      mem_in = r.mem_in;
      bundle = r.bundle;
      ops = r.ops;
   endtask

   task automatic report_mismatch(input string what, input int idx,
                                  input logic [127:0] expected, input logic [127:0] actual);
      $display("** Error at time %0t: row %0d, %s expected %h, got %h",
               $time, idx, what, expected, actual);
      $display("Test failed");
      $fatal(1, "writeback output mismatch");
   endtask

   task automatic check_outputs(input int idx, input row_t r);
      assert (gpr0 == r.gpr0) else report_mismatch("gpr0", idx, r.gpr0, gpr0);
      assert (gpr1 == r.gpr1) else report_mismatch("gpr1", idx, r.gpr1, gpr1);
      assert (spr == r.spr) else report_mismatch("spr", idx, r.spr, spr);
      assert (sspr == r.sspr) else report_mismatch("sspr", idx, r.sspr, sspr);
      assert (xercr == r.xercr) else report_mismatch("xercr", idx, r.xercr, xercr);
      assert (unlock_generic == r.unlock) else begin
         report_mismatch("unlock_generic", idx, r.unlock, unlock_generic);
      end
      assert (new_pcmsr == r.pcmsr) else report_mismatch("new_pcmsr", idx, r.pcmsr, new_pcmsr);
      assert (annul == r.annul) else report_mismatch("annul", idx, r.annul, annul);
   endtask

   initial begin
      reset = 1'b1;
      mem_in = '0;
      bundle = '0;
      ops = '0;
      rng = 32'd84742;
      dsi_pending = 1'b0;
      table_done = 1'b0;
      build_table();
      watchdog_ns = (rows.size() + 3 + 20) * 8;   // rows plus reset plus margin
      table_done = 1'b1;

      repeat (3) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;

      foreach (rows[i]) begin
         apply_row(rows[i]);
         #3;   // just before the rising edge
         check_outputs(i, rows[i]);
         @(negedge clk);
      end

      $display("Test completed successfully");
      $finish;
   end

   initial begin
      wait (table_done);
      #(watchdog_ns);
      $display("Watchdog expired: the row table did not finish in time");
      $display("Test failed");
      $fatal(1, "watchdog timeout");
   end

endmodule

/* writeback.f */
+incdir+.
wb_pkg.sv
wb_exc_calc.sv
wb_exc_sequencer.sv
wb_port_select.sv
writeback.sv
tb_writeback.sv
